// File: dv/xbar_golden.mem
// kind_a_b_op_count_id_addr, one hex digit for each of kind a b op
// 1 test a | 2 send a=ch | 3 expect a=bank b=ch | 4 allow a=mask b=random
// 5 free a=bank | 6 idle count | 7 drain | 8 status a=valid b=allow count=sends id=outputs
1_1_0_0_00_00_00000000
8_0_7_0_00_00_00000000
1_2_0_0_00_00_00000000
4_f_0_0_00_00_00000000
2_0_0_0_01_00_00000121
2_1_0_1_01_00_00000343
2_2_0_0_01_00_0abcdef2
2_2_0_0_01_00_00000130
3_1_0_0_01_00_00000121
3_3_1_1_01_00_00000343
3_2_2_0_01_00_0abcdef2
3_0_2_0_01_00_00000130
7_0_0_0_00_00_00000000
1_3_0_0_00_00_00000000
4_0_0_0_00_00_00000000
2_0_0_0_03_00_00000100
2_1_0_0_03_00_00000200
2_2_0_0_03_00_00000300
6_0_0_0_08_00_00000000
8_1_7_0_00_00_00000000
3_0_0_0_01_00_00000100
3_0_1_0_01_00_00000200
3_0_2_0_01_00_00000300
3_0_0_0_01_00_00000104
3_0_1_0_01_00_00000204
3_0_2_0_01_00_00000304
3_0_0_0_01_00_00000108
3_0_1_0_01_00_00000208
3_0_2_0_01_00_00000308
4_f_0_0_00_00_00000000
7_0_0_0_00_00_00000000
1_4_0_0_00_00_00000000
2_1_0_1_01_00_00000402
2_1_0_0_01_00_00000406
2_1_0_1_01_00_0000040a
2_1_0_1_01_00_0000040e
3_2_1_1_01_00_00000402
3_2_1_0_01_00_00000406
3_2_1_1_01_01_0000040a
3_2_1_1_01_02_0000040e
7_0_0_0_00_00_00000000
1_5_0_0_00_00_00000000
2_0_0_1_20_00_00001001
3_1_0_1_20_00_00001001
7_0_0_0_00_00_00000000
2_0_0_1_01_00_00002001
2_2_0_0_01_00_00003001
3_1_2_0_01_00_00003001
6_0_0_0_10_00_00000000
8_0_7_0_00_00_00000000
3_1_0_1_01_07_00002001
5_1_0_0_00_07_00000000
7_0_0_0_00_00_00000000
1_6_0_0_00_00_00000000
4_7_0_0_00_00_00000000
2_2_0_1_03_00_00004003
2_2_0_0_03_00_00005003
6_0_0_0_0c_00_00000000
8_8_3_0_02_00_00000000
3_3_2_1_03_01_00004003
3_3_2_0_03_00_00005003
4_f_1_0_00_00_00000000
7_0_0_0_00_00_00000000
f_0_0_0_00_00_00000000

// File: build.f
+incdir+include
hw/xbar_pkg.sv
hw/xbar_fifo.sv
hw/xbar_chan_buffer.sv
hw/xbar_rr_arbiter.sv
hw/xbar_wbuf_freelist.sv
hw/xbar_bank_port.sv
hw/xbar_core.sv
dv/xbar_clk_gen.sv
dv/xbar_props.sv
dv/xbar_tb.sv

// File: Bender.yml
package:
  name: xbar

export_include_dirs:
  - include

sources:
  - files:
      - hw/xbar_pkg.sv
      - hw/xbar_fifo.sv
      - hw/xbar_chan_buffer.sv
      - hw/xbar_rr_arbiter.sv
      - hw/xbar_wbuf_freelist.sv
      - hw/xbar_bank_port.sv
      - hw/xbar_core.sv
  - target: test
    files:
      - dv/xbar_clk_gen.sv
      - dv/xbar_props.sv
      - dv/xbar_tb.sv

// File: dv/xbar_tb.sv
`timescale 1ns/1ns

`include "xbar_settings.svh"

module xbar_tb;

  localparam int NUM_CH   = `XBAR_NUM_CH;
  localparam int NUM_BANK = `XBAR_NUM_BANK;
  localparam int MAX_REC  = 128;
  localparam int TIMEOUT  = 400;

  logic                 clk;
  logic                 rst_n;
  logic [NUM_CH-1:0]    chan_valid;
  xbar_pkg::chan_req_t  chan_req [NUM_CH];
  logic [NUM_CH-1:0]    chan_allow_in;
  logic [NUM_BANK-1:0]  bank_valid;
  xbar_pkg::bank_req_t  bank_req [NUM_BANK];
  logic [NUM_BANK-1:0]  bank_allow_in;
  xbar_pkg::wbuf_free_t bank_free [NUM_BANK];

  logic [63:0]          golden [MAX_REC];
  xbar_pkg::chan_req_t  send_q [NUM_CH][$];
  xbar_pkg::bank_req_t  exp_q [NUM_BANK][$];
  xbar_pkg::wbuf_free_t free_pend [NUM_BANK];
  logic [NUM_BANK-1:0]  allow_mask;
  logic                 rand_stall;
  logic [31:0]          lcg_state;
  int                   errors;
  int                   checks;
  int                   test_errors;
  int                   test_num;
  int                   tests_run;

  xbar_clk_gen #(
    .PERIOD     (20),
    .RST_CYCLES (10)
  ) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  xbar_core dut (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .chan_valid_i    (chan_valid),
    .chan_req_i      (chan_req),
    .chan_allow_in_o (chan_allow_in),
    .bank_valid_o    (bank_valid),
    .bank_req_o      (bank_req),
    .bank_allow_in_i (bank_allow_in),
    .bank_free_i     (bank_free)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int pending_sends();
    int n = 0;
    for (int c = 0; c < NUM_CH; c++) begin
      n += send_q[c].size();
    end
    return n;
  endfunction

  function automatic int pending_expects();
    int n = 0;
    for (int b = 0; b < NUM_BANK; b++) begin
      n += exp_q[b].size();
    end
    return n;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // ----------------------------------------
  // drive at the falling edge and observe 1 ns later
  // ----------------------------------------
  task automatic run_cycle();
    xbar_pkg::bank_req_t exp_req;
    xbar_pkg::bank_req_t got_req;
    @(negedge clk);
    for (int c = 0; c < NUM_CH; c++) begin
      chan_valid[c] = (send_q[c].size() > 0);
      chan_req[c]   = chan_valid[c] ? send_q[c][0] : '0;
    end
    for (int b = 0; b < NUM_BANK; b++) begin
      lcg_state        = lcg_next(lcg_state);
      bank_allow_in[b] = allow_mask[b] & ~(rand_stall & lcg_state[28]);
      bank_free[b]     = free_pend[b];
      free_pend[b]     = '0;
    end
    #1;
    for (int c = 0; c < NUM_CH; c++) begin
      if (chan_valid[c] && chan_allow_in[c]) begin
        send_q[c].delete(0);
      end
    end
    for (int b = 0; b < NUM_BANK; b++) begin
      if (bank_valid[b] && bank_allow_in[b]) begin
        if (exp_q[b].size() == 0) begin
          errors++;
          test_errors++;
          $display("error: unexpected transfer on bank %0d at %0t", b, $time);
        end else begin
          exp_req = exp_q[b].pop_front();
          got_req = bank_req[b];
          // id field only counts on writes
          if (exp_req.op != xbar_pkg::OP_WRITE) begin
            got_req.wbuf_id = '0;
          end
          check_value($sformatf("bank_req_o[%0d]", b), 64'(got_req), 64'(exp_req));
        end
      end
    end
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (!rst_n && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!rst_n) begin
      errors++;
      $display("error: reset was never released");
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (pending_sends() + pending_expects() > 0 && n < TIMEOUT) begin
      run_cycle();
      n++;
    end
    if (pending_sends() + pending_expects() > 0) begin
      errors++;
      test_errors++;
      $display("error: timeout in test %0d with %0d sends and %0d bank outputs outstanding",
               test_num, pending_sends(), pending_expects());
      for (int c = 0; c < NUM_CH; c++) begin
        send_q[c].delete();
      end
      for (int b = 0; b < NUM_BANK; b++) begin
        exp_q[b].delete();
      end
    end
  endtask

  task automatic end_test();
    if (test_num > 0) begin
      $display("test %0d done with %0d errors", test_num, test_errors);
      tests_run++;
    end
    test_errors = 0;
  endtask

  task automatic apply_record(input logic [63:0] rec);
    logic [3:0]          fa;
    logic [3:0]          fb;
    int                  cnt;
    logic [7:0]          id;
    logic [27:0]         addr;
    xbar_pkg::chan_req_t creq;
    xbar_pkg::bank_req_t breq;
    fa   = rec[59:56];
    fb   = rec[55:52];
    cnt  = int'(rec[47:40]);
    id   = rec[39:32];
    addr = rec[27:0];
    case (rec[63:60])
      4'h1: begin
        end_test();
        test_num = int'(fa);
      end
      4'h2: begin
        for (int i = 0; i < cnt; i++) begin
          creq.op   = xbar_pkg::op_e'(rec[49:48]);
          creq.addr = addr + 28'(4 * i);
          send_q[fa].push_back(creq);
        end
      end
      4'h3: begin
        // repeated writes take consecutive ids
        for (int i = 0; i < cnt; i++) begin
          breq.ch_id   = xbar_pkg::ch_id_t'(fb);
          breq.op      = xbar_pkg::op_e'(rec[49:48]);
          breq.addr    = addr + 28'(4 * i);
          breq.wbuf_id = (breq.op == xbar_pkg::OP_WRITE) ? 5'(id + 8'(i)) : '0;
          exp_q[fa].push_back(breq);
        end
      end
      4'h4: begin
        allow_mask = fa;
        rand_stall = fb[0];
      end
      4'h5: begin
        free_pend[fa].valid = 1'b1;
        free_pend[fa].id    = id[4:0];
        run_cycle();
      end
      4'h6: repeat (cnt) run_cycle();
      4'h7: drain();
      4'h8: begin
        check_value("bank_valid_o", 64'(bank_valid), 64'(fa));
        check_value("chan_allow_in_o", 64'(chan_allow_in), 64'(fb));
        check_value("pending sends", 64'(pending_sends()), 64'(cnt));
        check_value("pending bank outputs", 64'(pending_expects()), 64'(id));
      end
      default: begin
        errors++;
        $display("error: unknown record kind %h in the golden file", rec[63:60]);
      end
    endcase
  endtask

  initial begin
    int idx;
    chan_valid    = '0;
    bank_allow_in = '0;
    allow_mask    = '0;
    rand_stall    = 1'b0;
    lcg_state     = 32'hb0dc637d;
    errors        = 0;
    checks        = 0;
    test_errors   = 0;
    test_num      = 0;
    tests_run     = 0;
    for (int c = 0; c < NUM_CH; c++) begin
      chan_req[c] = '0;
    end
    for (int b = 0; b < NUM_BANK; b++) begin
      bank_free[b] = '0;
      free_pend[b] = '0;
    end
    $readmemh("dv/xbar_golden.mem", golden);
    wait_reset();
    run_cycle();
    idx = 0;
    while (idx < MAX_REC && golden[idx][63:60] != 4'hf) begin
      apply_record(golden[idx]);
      idx++;
    end
    end_test();
    if (tests_run == 0) begin
      errors++;
      $display("error: no test records were read from the golden file");
    end
    check_value("assertion failures", 64'(dut.u_props.fail_count), 64'd0);
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: dv/xbar_props.sv
`timescale 1ns/1ns

`include "xbar_settings.svh"

module xbar_props (
  input logic                      clk_i,
  input logic                      rst_n_i,
  input logic [`XBAR_NUM_CH-1:0]   chan_valid_i,
  input logic [`XBAR_NUM_CH-1:0]   chan_allow_in_o,
  input logic [`XBAR_NUM_BANK-1:0] bank_valid_o,
  input xbar_pkg::bank_req_t       bank_req_o [`XBAR_NUM_BANK],
  input logic [`XBAR_NUM_BANK-1:0] bank_allow_in_i,
  input xbar_pkg::wbuf_free_t      bank_free_i [`XBAR_NUM_BANK]
);

  localparam int NUM_ID = 1 << `XBAR_WBUF_AW;
  localparam int CNT_W  = $clog2(`XBAR_FIFO_DEPTH + 1);

  logic [`XBAR_NUM_BANK-1:0] xfer;
  logic [`XBAR_NUM_CH-1:0]   pop;
  logic [NUM_ID-1:0]         busy [`XBAR_NUM_BANK];
  logic [CNT_W-1:0]          occ  [`XBAR_NUM_CH];
  int                        fail_count = 0;

  assign xfer = bank_valid_o & bank_allow_in_i;

  // a channel pops when some bank takes its head
  always_comb begin
    pop = '0;
    for (int b = 0; b < `XBAR_NUM_BANK; b++) begin
      if (xfer[b]) begin
        pop[bank_req_o[b].ch_id] = 1'b1;
      end
    end
  end

  // ----------------------------------------
  // ids in use per bank, queue fill per channel
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int b = 0; b < `XBAR_NUM_BANK; b++) begin
        busy[b] <= '0;
      end
      for (int c = 0; c < `XBAR_NUM_CH; c++) begin
        occ[c] <= '0;
      end
    end else begin
      for (int b = 0; b < `XBAR_NUM_BANK; b++) begin
        if (xfer[b] && bank_req_o[b].op == xbar_pkg::OP_WRITE) begin
          busy[b][bank_req_o[b].wbuf_id] <= 1'b1;
        end
        if (bank_free_i[b].valid) begin
          busy[b][bank_free_i[b].id] <= 1'b0;
        end
      end
      for (int c = 0; c < `XBAR_NUM_CH; c++) begin
        occ[c] <= occ[c] + CNT_W'(chan_valid_i[c] & chan_allow_in_o[c]) - CNT_W'(pop[c]);
      end
    end
  end

  for (genvar b = 0; b < `XBAR_NUM_BANK; b++) begin : g_bank
    // stalled offer keeps its content
    a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      bank_valid_o[b] && !bank_allow_in_i[b] |=> bank_valid_o[b] && $stable(bank_req_o[b]))
      else begin
        fail_count++;
        $error("bank %0d request changed while stalled", b);
      end

    a_id_free : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      xfer[b] && bank_req_o[b].op == xbar_pkg::OP_WRITE |-> !busy[b][bank_req_o[b].wbuf_id])
      else begin
        fail_count++;
        $error("bank %0d handed out an id that is still in use", b);
      end
  end

  for (genvar c = 0; c < `XBAR_NUM_CH; c++) begin : g_chan
    a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      chan_valid_i[c] && chan_allow_in_o[c] |-> occ[c] < CNT_W'(`XBAR_FIFO_DEPTH))
      else begin
        fail_count++;
        $error("channel %0d accepted a request with a full queue", c);
      end
  end

endmodule

bind xbar_core xbar_props u_props (.*);

// File: dv/xbar_clk_gen.sv
`timescale 1ns/1ns

module xbar_clk_gen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // release away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: hw/xbar_core.sv
`timescale 1ns/1ns

`include "xbar_settings.svh"

module xbar_core (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [`XBAR_NUM_CH-1:0]   chan_valid_i,
  input  xbar_pkg::chan_req_t       chan_req_i [`XBAR_NUM_CH],
  output logic [`XBAR_NUM_CH-1:0]   chan_allow_in_o,
  output logic [`XBAR_NUM_BANK-1:0] bank_valid_o,
  output xbar_pkg::bank_req_t       bank_req_o [`XBAR_NUM_BANK],
  input  logic [`XBAR_NUM_BANK-1:0] bank_allow_in_i,
  input  xbar_pkg::wbuf_free_t      bank_free_i [`XBAR_NUM_BANK]
);

  logic [`XBAR_NUM_BANK-1:0] want_by_ch    [`XBAR_NUM_CH];
  logic [`XBAR_NUM_BANK-1:0] grant_by_ch   [`XBAR_NUM_CH];
  logic [`XBAR_NUM_CH-1:0]   want_by_bank  [`XBAR_NUM_BANK];
  logic [`XBAR_NUM_CH-1:0]   grant_by_bank [`XBAR_NUM_BANK];
  xbar_pkg::chan_req_t       heads         [`XBAR_NUM_CH];

  // ----------------------------------------
  // channel queues
  // ----------------------------------------
  for (genvar c = 0; c < `XBAR_NUM_CH; c++) begin : g_chan
    xbar_chan_buffer u_buf (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .valid_i    (chan_valid_i[c]),
      .req_i      (chan_req_i[c]),
      .allow_in_o (chan_allow_in_o[c]),
      .want_o     (want_by_ch[c]),
      .head_o     (heads[c]),
      .grant_i    (grant_by_ch[c])
    );
  end

  // channel-major to bank-major and back
  for (genvar b = 0; b < `XBAR_NUM_BANK; b++) begin : g_xpose_bank
    for (genvar c = 0; c < `XBAR_NUM_CH; c++) begin : g_xpose_ch
      assign want_by_bank[b][c] = want_by_ch[c][b];
      assign grant_by_ch[c][b]  = grant_by_bank[b][c];
    end
  end

  // ----------------------------------------
  // bank ports
  // ----------------------------------------
  for (genvar b = 0; b < `XBAR_NUM_BANK; b++) begin : g_bank
    xbar_bank_port u_port (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .want_i          (want_by_bank[b]),
      .heads_i         (heads),
      .grant_o         (grant_by_bank[b]),
      .bank_valid_o    (bank_valid_o[b]),
      .bank_req_o      (bank_req_o[b]),
      .bank_allow_in_i (bank_allow_in_i[b]),
      .bank_free_i     (bank_free_i[b])
    );
  end

endmodule

// File: hw/xbar_bank_port.sv
`timescale 1ns/1ns

`include "xbar_settings.svh"

module xbar_bank_port (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic [`XBAR_NUM_CH-1:0] want_i,
  input  xbar_pkg::chan_req_t     heads_i [`XBAR_NUM_CH],
  output logic [`XBAR_NUM_CH-1:0] grant_o,
  output logic                    bank_valid_o,
  output xbar_pkg::bank_req_t     bank_req_o,
  input  logic                    bank_allow_in_i,
  input  xbar_pkg::wbuf_free_t    bank_free_i
);

  logic [`XBAR_NUM_CH-1:0] eligible;
  logic [`XBAR_NUM_CH-1:0] arb_req;
  logic [`XBAR_NUM_CH-1:0] sel;
  logic [`XBAR_NUM_CH-1:0] held_sel;
  logic                    held;
  logic                    xfer;
  logic                    win_write;
  logic                    id_avail;
  xbar_pkg::wbuf_id_t      free_id;
  xbar_pkg::ch_id_t        win;

  // writes wait while the pool is empty, reads always go
  always_comb begin
    for (int c = 0; c < `XBAR_NUM_CH; c++) begin
      eligible[c] = want_i[c] & (id_avail | (heads_i[c].op != xbar_pkg::OP_WRITE));
    end
  end

  // ----------------------------------------
  // arbitration
  // ----------------------------------------
  // a stalled offer keeps its channel so the output does not change
  assign arb_req = held ? held_sel : eligible;

  xbar_rr_arbiter #(
    .N (`XBAR_NUM_CH)
  ) u_arb (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (arb_req),
    .advance_i (xfer),
    .grant_o   (sel)
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      held     <= 1'b0;
      held_sel <= '0;
    end else begin
      held     <= bank_valid_o & ~bank_allow_in_i;
      held_sel <= sel;
    end
  end

  // ----------------------------------------
  // request mux and handshake
  // ----------------------------------------
  always_comb begin
    win = '0;
    for (int c = 0; c < `XBAR_NUM_CH; c++) begin
      if (sel[c]) begin
        win = xbar_pkg::ch_id_t'(c);
      end
    end
  end

  assign win_write    = (heads_i[win].op == xbar_pkg::OP_WRITE);
  assign bank_valid_o = |sel;
  assign xfer         = bank_valid_o & bank_allow_in_i;
  assign grant_o      = sel & {`XBAR_NUM_CH{xfer}};

  // id field is zero on reads
  always_comb begin
    bank_req_o.ch_id   = win;
    bank_req_o.op      = heads_i[win].op;
    bank_req_o.addr    = heads_i[win].addr;
    bank_req_o.wbuf_id = win_write ? free_id : '0;
  end

  xbar_wbuf_freelist u_freelist (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .alloc_i (xfer & win_write),
    .id_o    (free_id),
    .avail_o (id_avail),
    .free_i  (bank_free_i)
  );

endmodule

// File: hw/xbar_wbuf_freelist.sv
`timescale 1ns/1ns

`include "xbar_settings.svh"

module xbar_wbuf_freelist (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 alloc_i,
  output xbar_pkg::wbuf_id_t   id_o,
  output logic                 avail_o,
  input  xbar_pkg::wbuf_free_t free_i
);

  localparam int NUM_ID = 1 << `XBAR_WBUF_AW;

  logic [`XBAR_WBUF_AW:0] init_cnt;
  logic                   init_done;
  logic                   push;
  logic                   empty;
  xbar_pkg::wbuf_id_t     push_id;

  // msb of the counter marks the pool as filled
  assign init_done = init_cnt[`XBAR_WBUF_AW];

  // ids 0..NUM_ID-1 first, freed ids afterwards
  assign push    = init_done ? free_i.valid : 1'b1;
  assign push_id = init_done ? free_i.id : init_cnt[`XBAR_WBUF_AW-1:0];
  assign avail_o = init_done & ~empty;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      init_cnt <= '0;
    end else if (!init_done) begin
      init_cnt <= init_cnt + 1'b1;
    end
  end

  xbar_fifo #(
    .T     (xbar_pkg::wbuf_id_t),
    .DEPTH (NUM_ID)
  ) u_pool (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (push),
    .data_i  (push_id),
    .pop_i   (alloc_i & avail_o),
    .data_o  (id_o),
    .empty_o (empty),
    .full_o  ()
  );

endmodule

// File: hw/xbar_rr_arbiter.sv
`timescale 1ns/1ns

`include "xbar_settings.svh"

module xbar_rr_arbiter #(
  parameter int N = `XBAR_NUM_CH
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic [N-1:0] req_i,
  input  logic         advance_i,
  output logic [N-1:0] grant_o
);

  localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

  logic [PTR_W-1:0] ptr;
  logic [PTR_W-1:0] win;
  logic             found;

  // first requester at or after the pointer, wrapping once
  always_comb begin
    grant_o = '0;
    win     = ptr;
    found   = 1'b0;
    for (int i = 0; i < N; i++) begin
      if (!found && req_i[(int'(ptr) + i) % N]) begin
        found = 1'b1;
        win   = PTR_W'((int'(ptr) + i) % N);
      end
    end
    if (found) begin
      grant_o[win] = 1'b1;
    end
  end

  // pointer moves past the winner only on a transfer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr <= '0;
    end else if (advance_i && found) begin
      ptr <= (win == PTR_W'(N - 1)) ? '0 : win + 1'b1;
    end
  end

endmodule

// File: hw/xbar_chan_buffer.sv
`timescale 1ns/1ns

`include "xbar_settings.svh"

module xbar_chan_buffer (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      valid_i,
  input  xbar_pkg::chan_req_t       req_i,
  output logic                      allow_in_o,
  output logic [`XBAR_NUM_BANK-1:0] want_o,
  output xbar_pkg::chan_req_t       head_o,
  input  logic [`XBAR_NUM_BANK-1:0] grant_i
);

  localparam int BANK_SEL_W = $clog2(`XBAR_NUM_BANK);

  logic                  empty;
  logic                  full;
  logic                  push;
  logic                  pop;
  logic [BANK_SEL_W-1:0] bank_sel;

  // accept while there is room
  assign allow_in_o = ~full;
  assign push       = valid_i & ~full;

  // a grant only comes with a bank transfer
  assign pop = |grant_i;

  xbar_fifo #(
    .T     (xbar_pkg::chan_req_t),
    .DEPTH (`XBAR_FIFO_DEPTH)
  ) u_queue (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (push),
    .data_i  (req_i),
    .pop_i   (pop),
    .data_o  (head_o),
    .empty_o (empty),
    .full_o  (full)
  );

  // ----------------------------------------
  // bank decode of the head entry
  // ----------------------------------------
  assign bank_sel = head_o.addr[`XBAR_BANK_LSB +: BANK_SEL_W];

  always_comb begin
    want_o = '0;
    if (!empty) begin
      want_o[bank_sel] = 1'b1;
    end
  end

endmodule

// File: hw/xbar_fifo.sv
`timescale 1ns/1ns

module xbar_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic empty_o,
  output logic full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign empty_o = (count == '0);
  assign full_o  = (count == CNT_W'(DEPTH));
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // pointers wrap at DEPTH, count tracks occupancy
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: hw/xbar_pkg.sv
`include "xbar_settings.svh"

package xbar_pkg;

  // 2'b10 and 2'b11 travel through as reads
  typedef enum logic [1:0] {
    OP_READ  = 2'b00,
    OP_WRITE = 2'b01
  } op_e;

  typedef logic [`XBAR_ADDR_HI:`XBAR_ADDR_LO] line_addr_t;
  typedef logic [$clog2(`XBAR_NUM_CH)-1:0]    ch_id_t;
  typedef logic [`XBAR_WBUF_AW-1:0]           wbuf_id_t;

  // request as it arrives on a channel
  typedef struct packed {
    op_e        op;
    line_addr_t addr;
  } chan_req_t;

  // request as presented to a bank
  typedef struct packed {
    ch_id_t     ch_id;
    op_e        op;
    line_addr_t addr;
    wbuf_id_t   wbuf_id;
  } bank_req_t;

  typedef struct packed {
    logic     valid;
    wbuf_id_t id;
  } wbuf_free_t;

endpackage

// File: include/xbar_settings.svh
`ifndef XBAR_SETTINGS_SVH
`define XBAR_SETTINGS_SVH

// ----------------------------------------
// crossbar sizing
// ----------------------------------------

// requester channels and cache banks
`define XBAR_NUM_CH     3
`define XBAR_NUM_BANK   4

// entries per channel queue
`define XBAR_FIFO_DEPTH 4

// line address bounds
`define XBAR_ADDR_HI    31
`define XBAR_ADDR_LO    4

// bank select field starts here and is two bits wide
`define XBAR_BANK_LSB   4

// write buffer id width
`define XBAR_WBUF_AW    5

`endif
